//--- design/game_pkg.sv
package game_pkg;

    // obstacle word: [15:13] type, [12:11] lane, [10:0] far-end depth
    localparam int OBSTACLE_W = 16;
    localparam int TYPE_LSB   = 13;
    localparam int LANE_LSB   = 11;
    localparam int DEPTH_W    = 11;

    localparam int COORD_W = 16;  // one signed coordinate

    typedef enum logic [2:0] {
        NONE         = 3'd0,
        LOW_BARRIER  = 3'd1,  // must jump
        HIGH_BARRIER = 3'd2,  // must duck
        MID_BARRIER  = 3'd3,  // jump or duck
        TRAIN_CAR    = 3'd4,
        RAMP         = 3'd5,
        MOVING_CAR   = 3'd6   // not drawn
    } obstacle_kind_t;

    // lane edges in x, lane codes 2 and 3 are both the right lane
    localparam int LEFT_LANE_L  = -128;
    localparam int LEFT_LANE_R  = -64;
    localparam int MID_LANE_L   = -32;
    localparam int MID_LANE_R   = 32;
    localparam int RIGHT_LANE_L = 64;
    localparam int RIGHT_LANE_R = 128;

    // y grows downwards
    localparam int Y_GROUND = 128;
    localparam int Y_MID    = 96;
    localparam int Y_TOP    = 64;
    localparam int BAR_HALF = 8;

    localparam int BARRIER_LEN = 32;
    localparam int CAR_LEN     = 128;  // cars and ramps

    function automatic logic is_barrier(obstacle_kind_t k);
        return k inside {LOW_BARRIER, HIGH_BARRIER, MID_BARRIER};
    endfunction

endpackage

//--- design/render_pkg.sv
package render_pkg;

    localparam int VERTEX_W = 48;  // {x, y, z}
    localparam int COLOR_W  = 16;

    localparam logic [COLOR_W-1:0] COL_BARRIER   = 16'hF000;
    localparam logic [COLOR_W-1:0] COL_CAR_FRONT = 16'h001F;
    localparam logic [COLOR_W-1:0] COL_CAR_LEFT  = 16'h000F;
    localparam logic [COLOR_W-1:0] COL_CAR_RIGHT = 16'h000A;
    localparam logic [COLOR_W-1:0] COL_CAR_TOP   = 16'h312F;
    localparam logic [COLOR_W-1:0] COL_RAMP_SIDE = 16'hFEE4;
    localparam logic [COLOR_W-1:0] COL_RAMP_TOP  = 16'h8200;

    localparam int VIDX_W = 5;

    // vertices per shape, three per triangle
    localparam int BARRIER_VERTS = 6;
    localparam int CAR_VERTS     = 24;
    localparam int RAMP_VERTS    = 18;

    // height select, five levels so three bits
    typedef enum logic [2:0] {
        GROUND = 3'd0,
        MID    = 3'd1,
        TOP    = 3'd2,
        BAR_LO = 3'd3,  // middle barrier, MID - BAR_HALF
        BAR_HI = 3'd4   // middle barrier, MID + BAR_HALF
    } y_sel_t;

    // one-bit corner selects
    localparam logic X_LEFT  = 1'b0;
    localparam logic X_RIGHT = 1'b1;
    localparam logic Z_NEAR  = 1'b0;
    localparam logic Z_FAR   = 1'b1;

endpackage

//--- design/obstacle_decoder.sv
`timescale 1ns/100ps

module obstacle_decoder import game_pkg::*; #(
    parameter int MIN_Z = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [OBSTACLE_W-1:0]     wb_dat,
    output logic                      wb_ack,
    input  logic                      busy,
    output logic                      start,
    output obstacle_kind_t            kind,
    output logic signed [COORD_W-1:0] lane_left,
    output logic signed [COORD_W-1:0] lane_right,
    output logic signed [DEPTH_W:0]   depth
);

    logic                    pending;
    logic                    take_write;
    logic                    drawable;
    obstacle_kind_t          kind_in;
    logic [1:0]              lane_in;
    logic signed [DEPTH_W:0] depth_in;

    assign pending    = wb_cyc && wb_stb && !wb_ack;  // ack is a single pulse
    assign take_write = pending && wb_we && !busy;

    assign kind_in  = obstacle_kind_t'(wb_dat[TYPE_LSB +: $bits(obstacle_kind_t)]);
    assign lane_in  = wb_dat[LANE_LSB +: 2];
    assign depth_in = $signed({1'b0, wb_dat[DEPTH_W-1:0]});

    // barriers too close to the camera are culled
    always_comb begin
        if (is_barrier(kind_in)) begin
            drawable = depth_in >= BARRIER_LEN + MIN_Z;
        end else begin
            drawable = kind_in inside {TRAIN_CAR, RAMP};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
        end else begin
            wb_ack <= pending && (!wb_we || !busy);  // reads acked at once
            start  <= take_write && drawable;
        end
    end

    always_ff @(posedge clk) begin
        if (take_write) begin
            kind  <= kind_in;
            depth <= depth_in;
            case (lane_in)
                2'd0: begin
                    lane_left  <= COORD_W'(LEFT_LANE_L);
                    lane_right <= COORD_W'(LEFT_LANE_R);
                end
                2'd1: begin
                    lane_left  <= COORD_W'(MID_LANE_L);
                    lane_right <= COORD_W'(MID_LANE_R);
                end
                default: begin
                    lane_left  <= COORD_W'(RIGHT_LANE_L);
                    lane_right <= COORD_W'(RIGHT_LANE_R);
                end
            endcase
        end
    end

endmodule

//--- design/shape_rom.sv
`timescale 1ns/100ps

module shape_rom import game_pkg::*, render_pkg::*; (
    input  obstacle_kind_t     kind,
    input  logic [VIDX_W-1:0]  vidx,
    output logic               x_sel,
    output logic               z_sel,
    output y_sel_t             y_sel,
    output logic [COLOR_W-1:0] color,
    output logic               last
);

    // corner patterns of one face, bit i is vertex i of the face
    // x: 1 = right edge, hi: 1 = upper level, z: 1 = far end
    localparam logic [5:0] QUAD_X      = 6'b011010;
    localparam logic [5:0] QUAD_HI     = 6'b110100;
    localparam logic [5:0] QUAD_Z      = 6'b000000;
    localparam logic [5:0] LEFT_HI     = 6'b011010;
    localparam logic [5:0] LEFT_Z      = 6'b110100;
    localparam logic [5:0] SIDE_HI     = 6'b010011;  // car right side, ramp sides
    localparam logic [5:0] SIDE_Z      = 6'b110010;
    localparam logic [5:0] TOP_X       = 6'b001110;
    localparam logic [5:0] TOP_Z       = 6'b011100;
    localparam logic [5:0] RAMP_TOP_HI = 6'b011100;

    logic [1:0] face;
    logic [2:0] corner;
    logic [5:0] x_pat;
    logic [5:0] hi_pat;
    logic [5:0] z_pat;
    y_sel_t     y_lo;
    y_sel_t     y_hi;

    // six vertices per face
    always_comb begin
        if (vidx < VIDX_W'(6)) begin
            face   = 2'd0;
            corner = vidx[2:0];
        end else if (vidx < VIDX_W'(12)) begin
            face   = 2'd1;
            corner = 3'(vidx - VIDX_W'(6));
        end else if (vidx < VIDX_W'(18)) begin
            face   = 2'd2;
            corner = 3'(vidx - VIDX_W'(12));
        end else begin
            face   = 2'd3;
            corner = 3'(vidx - VIDX_W'(18));
        end
    end

    always_comb begin
        x_pat  = QUAD_X;  // barriers and car front
        hi_pat = QUAD_HI;
        z_pat  = QUAD_Z;
        color  = COL_BARRIER;
        last   = 1'b0;
        case (kind)
            LOW_BARRIER, HIGH_BARRIER, MID_BARRIER: begin
                last = vidx == VIDX_W'(BARRIER_VERTS - 1);
            end
            TRAIN_CAR: begin
                last = vidx == VIDX_W'(CAR_VERTS - 1);
                case (face)
                    2'd0: color = COL_CAR_FRONT;
                    2'd1: begin
                        x_pat  = {6{X_LEFT}};
                        hi_pat = LEFT_HI;
                        z_pat  = LEFT_Z;
                        color  = COL_CAR_LEFT;
                    end
                    2'd2: begin
                        x_pat  = {6{X_RIGHT}};
                        hi_pat = SIDE_HI;
                        z_pat  = SIDE_Z;
                        color  = COL_CAR_RIGHT;
                    end
                    default: begin
                        x_pat  = TOP_X;
                        hi_pat = 6'b111111;
                        z_pat  = TOP_Z;
                        color  = COL_CAR_TOP;
                    end
                endcase
            end
            RAMP: begin
                last = vidx == VIDX_W'(RAMP_VERTS - 1);
                if (face == 2'd2) begin
                    x_pat  = TOP_X;
                    hi_pat = RAMP_TOP_HI;
                    z_pat  = TOP_Z;
                    color  = COL_RAMP_TOP;
                end else begin
                    x_pat  = {6{face[0]}};  // left side first, then right
                    hi_pat = SIDE_HI;
                    z_pat  = SIDE_Z;
                    color  = COL_RAMP_SIDE;
                end
            end
            default: begin
                color = '0;  // nothing to draw
                last  = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (kind)
            LOW_BARRIER: begin
                y_lo = GROUND;
                y_hi = MID;
            end
            HIGH_BARRIER: begin
                y_lo = MID;
                y_hi = TOP;
            end
            MID_BARRIER: begin
                y_lo = BAR_LO;
                y_hi = BAR_HI;
            end
            default: begin
                y_lo = GROUND;
                y_hi = TOP;
            end
        endcase
    end

    assign x_sel = x_pat[corner];
    assign z_sel = z_pat[corner];
    assign y_sel = hi_pat[corner] ? y_hi : y_lo;

endmodule

//--- design/triangle_sequencer.sv
`timescale 1ns/100ps

module triangle_sequencer import render_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              last,
    output logic [VIDX_W-1:0] vidx,
    output logic              active,
    output logic              first_of_tri,
    output logic              busy
);

    localparam logic IDLE = 1'b0;
    localparam logic GEN  = 1'b1;

    logic       state;
    logic [1:0] tri_pos;  // position inside the current triangle

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            vidx    <= '0;
            tri_pos <= 2'd0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= GEN;
                        vidx    <= '0;
                        tri_pos <= 2'd0;
                    end
                end
                default: begin
                    if (last) begin
                        state <= IDLE;  // final index of the shape
                    end else begin
                        vidx <= vidx + 1'b1;
                        if (tri_pos == 2'd2) begin
                            tri_pos <= 2'd0;
                        end else begin
                            tri_pos <= tri_pos + 2'd1;
                        end
                    end
                end
            endcase
        end
    end

    assign active       = state == GEN;
    assign first_of_tri = tri_pos == 2'd0;

    // covers the start cycle so the decoder holds off right away
    assign busy = start || active;

endmodule

//--- design/vertex_emitter.sv
`timescale 1ns/100ps

module vertex_emitter import game_pkg::*, render_pkg::*; #(
    parameter int MIN_Z    = 8,
    parameter int Z_OFFSET = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      active,
    input  logic                      first_of_tri,
    input  logic                      x_sel,
    input  logic                      z_sel,
    input  y_sel_t                    y_sel,
    input  logic [COLOR_W-1:0]        color_in,
    input  obstacle_kind_t            kind,
    input  logic signed [COORD_W-1:0] lane_left,
    input  logic signed [COORD_W-1:0] lane_right,
    input  logic signed [DEPTH_W:0]   depth,
    output logic [VERTEX_W-1:0]       vertex,
    output logic [COLOR_W-1:0]        color,
    output logic                      vertex_valid,
    output logic                      new_triangle
);

    logic signed [COORD_W-1:0] x;
    logic signed [COORD_W-1:0] y;
    logic signed [COORD_W-1:0] depth_ext;
    logic signed [COORD_W-1:0] near_len;
    logic signed [COORD_W-1:0] z_raw;
    logic signed [COORD_W-1:0] z_clamp;

    assign x = (x_sel == X_RIGHT) ? lane_right : lane_left;

    always_comb begin
        case (y_sel)
            MID:     y = COORD_W'(Y_MID);
            TOP:     y = COORD_W'(Y_TOP);
            BAR_LO:  y = COORD_W'(Y_MID - BAR_HALF);
            BAR_HI:  y = COORD_W'(Y_MID + BAR_HALF);
            default: y = COORD_W'(Y_GROUND);
        endcase
    end

    // depth marks the far end, near end sits one shape length closer
    assign depth_ext = COORD_W'(depth);
    assign near_len  = is_barrier(kind) ? COORD_W'(BARRIER_LEN) : COORD_W'(CAR_LEN);
    assign z_raw     = (z_sel == Z_FAR) ? depth_ext : depth_ext - near_len;
    assign z_clamp   = (z_raw < COORD_W'(MIN_Z)) ? COORD_W'(MIN_Z) : z_raw;

    always_ff @(posedge clk) begin
        vertex <= {x, y, z_clamp + COORD_W'(Z_OFFSET)};
        color  <= color_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vertex_valid <= 1'b0;
            new_triangle <= 1'b0;
        end else begin
            vertex_valid <= active;
            new_triangle <= active && first_of_tri;
        end
    end

endmodule

//--- design/triangle_creator.sv
`timescale 1ns/100ps

module triangle_creator import game_pkg::*, render_pkg::*; #(
    parameter int MIN_Z    = 8,
    parameter int Z_OFFSET = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [OBSTACLE_W-1:0] wb_dat,
    output logic                  wb_ack,
    output logic [VERTEX_W-1:0]   vertex,
    output logic [COLOR_W-1:0]    color,
    output logic                  vertex_valid,
    output logic                  new_triangle
);

    logic                      start;
    logic                      busy;
    obstacle_kind_t            kind;
    logic signed [COORD_W-1:0] lane_left;
    logic signed [COORD_W-1:0] lane_right;
    logic signed [DEPTH_W:0]   depth;
    logic [VIDX_W-1:0]         vidx;
    logic                      active;
    logic                      first_of_tri;
    logic                      x_sel;
    logic                      z_sel;
    y_sel_t                    y_sel;
    logic [COLOR_W-1:0]        rom_color;
    logic                      last;

    obstacle_decoder #(
        .MIN_Z (MIN_Z)
    ) i_obstacle_decoder (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_dat     (wb_dat),
        .wb_ack     (wb_ack),
        .busy       (busy),
        .start      (start),
        .kind       (kind),
        .lane_left  (lane_left),
        .lane_right (lane_right),
        .depth      (depth)
    );

    triangle_sequencer i_triangle_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .last         (last),
        .vidx         (vidx),
        .active       (active),
        .first_of_tri (first_of_tri),
        .busy         (busy)
    );

    shape_rom i_shape_rom (
        .kind  (kind),
        .vidx  (vidx),
        .x_sel (x_sel),
        .z_sel (z_sel),
        .y_sel (y_sel),
        .color (rom_color),
        .last  (last)
    );

    vertex_emitter #(
        .MIN_Z    (MIN_Z),
        .Z_OFFSET (Z_OFFSET)
    ) i_vertex_emitter (
        .clk          (clk),
        .rst          (rst),
        .active       (active),
        .first_of_tri (first_of_tri),
        .x_sel        (x_sel),
        .z_sel        (z_sel),
        .y_sel        (y_sel),
        .color_in     (rom_color),
        .kind         (kind),
        .lane_left    (lane_left),
        .lane_right   (lane_right),
        .depth        (depth),
        .vertex       (vertex),
        .color        (color),
        .vertex_valid (vertex_valid),
        .new_triangle (new_triangle)
    );

endmodule

//--- verification/triangle_creator_properties.sv
`timescale 1ns/100ps

module triangle_creator_properties (
    input logic clk,
    input logic rst,
    input logic wb_ack,
    input logic active,
    input logic vertex_valid,
    input logic new_triangle
);

    int unsigned failures = 0;  // read by the testbench summary

    // ack is a single-cycle pulse
    ack_single_pulse: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
    else begin
        $error("wb_ack was high on two consecutive cycles");
        failures++;
    end

    // output stage lags the sequencer by one cycle
    no_vertex_when_idle: assert property (@(posedge clk) disable iff (rst)
        (!$past(active) && !active) |-> !vertex_valid)
    else begin
        $error("vertex_valid seen while the sequencer was idle");
        failures++;
    end

    strobe_within_stream: assert property (@(posedge clk) disable iff (rst)
        new_triangle |-> vertex_valid)
    else begin
        $error("new_triangle seen without vertex_valid");
        failures++;
    end

endmodule

bind triangle_creator triangle_creator_properties i_triangle_creator_properties (
    .clk          (clk),
    .rst          (rst),
    .wb_ack       (wb_ack),
    .active       (active),
    .vertex_valid (vertex_valid),
    .new_triangle (new_triangle)
);

//--- verification/triangle_creator_tb.sv
`timescale 1ns/100ps

module triangle_creator_tb import game_pkg::*, render_pkg::*; ();

    localparam int          MIN_Z          = 8;
    localparam int          Z_OFFSET       = 16;
    localparam int          TIMEOUT_CYCLES = 4000;  // all tests need well under 1000
    localparam logic [31:0] RAND_SEED      = 32'h3cede656;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [OBSTACLE_W-1:0] wb_dat;
    logic                  wb_ack;
    logic [VERTEX_W-1:0]   vertex;
    logic [COLOR_W-1:0]    color;
    logic                  vertex_valid;
    logic                  new_triangle;

    logic [VERTEX_W-1:0] got_v[$];
    logic [COLOR_W-1:0]  got_c[$];
    logic                got_t[$];
    logic [VERTEX_W-1:0] exp_v[$];
    logic [COLOR_W-1:0]  exp_c[$];
    logic                exp_t[$];

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned cycles = 0;

    // lane code to edge x, code 3 is the right lane too
    int lane_l [4] = '{LEFT_LANE_L, MID_LANE_L, RIGHT_LANE_L, RIGHT_LANE_L};
    int lane_r [4] = '{LEFT_LANE_R, MID_LANE_R, RIGHT_LANE_R, RIGHT_LANE_R};
    logic [COLOR_W-1:0] car_colors [4] = '{COL_CAR_FRONT, COL_CAR_LEFT,
                                          COL_CAR_RIGHT, COL_CAR_TOP};

    triangle_creator #(
        .MIN_Z    (MIN_Z),
        .Z_OFFSET (Z_OFFSET)
    ) i_triangle_creator (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack),
        .vertex       (vertex),
        .color        (color),
        .vertex_valid (vertex_valid),
        .new_triangle (new_triangle)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (vertex_valid) begin  // capture the stream
            got_v.push_back(vertex);
            got_c.push_back(color);
            got_t.push_back(new_triangle);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input logic [47:0] actual, input logic [47:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [OBSTACLE_W-1:0] obstacle_word(int kind, int lane, int depth);
        return {3'(kind), 2'(lane), 11'(depth)};
    endfunction

    task automatic wb_write(input logic [OBSTACLE_W-1:0] word);
        @(posedge clk);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_dat = word;
        do @(posedge clk); while (!wb_ack);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // corner codes per vertex: x right, upper level, far end
    task automatic expect_shape(input int kind, input int lane, input int depth);
        string codes;
        int    c;
        int    ylo;
        int    yhi;
        int    len;
        int    x;
        int    y;
        int    z;
        ylo   = Y_GROUND;
        yhi   = Y_TOP;
        len   = (kind == TRAIN_CAR || kind == RAMP) ? CAR_LEN : BARRIER_LEN;
        codes = "042462";
        if (kind == LOW_BARRIER) begin
            yhi = Y_MID;
        end else if (kind == HIGH_BARRIER) begin
            ylo = Y_MID;
        end else if (kind == MID_BARRIER) begin
            ylo = Y_MID - BAR_HALF;
            yhi = Y_MID + BAR_HALF;
        end else if (kind == TRAIN_CAR) begin
            codes = "042462021231674475267732";  // front, left, right, top
        end else begin
            codes = "230031674475047730";  // left side, right side, top
        end
        for (int i = 0; i < codes.len(); i++) begin
            c = codes[i] - 48;
            x = c[2] ? lane_r[lane] : lane_l[lane];
            y = c[1] ? yhi : ylo;
            z = c[0] ? depth : depth - len;
            if (z < MIN_Z) z = MIN_Z;
            exp_v.push_back({16'(x), 16'(y), 16'(z + Z_OFFSET)});
            if (kind == TRAIN_CAR) begin
                exp_c.push_back(car_colors[i / 6]);
            end else if (kind == RAMP) begin
                exp_c.push_back((i >= 12) ? COL_RAMP_TOP : COL_RAMP_SIDE);
            end else begin
                exp_c.push_back(COL_BARRIER);
            end
            exp_t.push_back(i % 3 == 0);
        end
    endtask

    task automatic check_stream(input string name);
        while (got_v.size() < exp_v.size()) @(posedge clk);
        repeat (4) @(posedge clk);  // catch any extra vertex
        check_value(got_v.size(), exp_v.size(), {name, " vertex count"});
        for (int i = 0; i < exp_v.size() && i < got_v.size(); i++) begin
            check_value(got_v[i], exp_v[i], $sformatf("%s vertex %0d", name, i));
            check_value(got_c[i], exp_c[i], $sformatf("%s color %0d", name, i));
            check_value(got_t[i], exp_t[i], $sformatf("%s new_triangle %0d", name, i));
        end
        got_v.delete();
        got_c.delete();
        got_t.delete();
        exp_v.delete();
        exp_c.delete();
        exp_t.delete();
    endtask

    task automatic draw_and_check(input int kind, input int lane, input int depth,
                                  input string name);
        expect_shape(kind, lane, depth);
        wb_write(obstacle_word(kind, lane, depth));
        check_stream(name);
    endtask

    task automatic test_low_barrier_lanes();
        for (int lane = 0; lane < 4; lane++) begin
            draw_and_check(LOW_BARRIER, lane, 200, $sformatf("low barrier lane %0d", lane));
        end
    endtask

    task automatic test_high_mid_barriers();
        repeat (3) begin
            draw_and_check(HIGH_BARRIER, $urandom % 4, 40 + $urandom % 2000, "high barrier");
            draw_and_check(MID_BARRIER, $urandom % 4, 40 + $urandom % 2000, "middle barrier");
        end
    endtask

    task automatic test_train_car();
        draw_and_check(TRAIN_CAR, $urandom % 4, 700, "train car");
    endtask

    task automatic test_ramp_clamp();
        draw_and_check(RAMP, 1, 40, "ramp near camera");
        draw_and_check(RAMP, 2, 600, "ramp far away");
    endtask

    task automatic test_culled();
        int kinds [4] = '{LOW_BARRIER, NONE, MOVING_CAR, 7};
        for (int i = 0; i < 4; i++) begin
            wb_write(obstacle_word(kinds[i], 1, 39));  // 39 culls a barrier
            repeat (40) @(posedge clk);
            check_value(got_v.size(), 0, $sformatf("vertices from culled type %0d", kinds[i]));
        end
    endtask

    task automatic test_back_pressure();
        expect_shape(TRAIN_CAR, 1, 500);
        expect_shape(LOW_BARRIER, 2, 300);
        wb_write(obstacle_word(TRAIN_CAR, 1, 500));
        while (got_v.size() == 0) @(posedge clk);
        wb_write(obstacle_word(LOW_BARRIER, 2, 300));  // held off until the car is out
        check_value(got_v.size(), CAR_VERTS, "car vertices before second ack");
        check_stream("car then barrier");
    endtask

    initial begin
        rst    = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_dat = '0;
        void'($urandom(RAND_SEED));
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        check_value(wb_ack, 0, "wb_ack after reset");
        check_value(vertex_valid, 0, "vertex_valid after reset");
        check_value(new_triangle, 0, "new_triangle after reset");

        test_low_barrier_lanes();
        test_high_mid_barriers();
        test_train_car();
        test_ramp_clamp();
        test_culled();
        test_back_pressure();

        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 i_triangle_creator.i_triangle_creator_properties.failures);
        if (errors == 0 && i_triangle_creator.i_triangle_creator_properties.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
design/game_pkg.sv
design/render_pkg.sv
design/obstacle_decoder.sv
design/shape_rom.sv
design/triangle_sequencer.sv
design/vertex_emitter.sv
design/triangle_creator.sv
verification/triangle_creator_properties.sv
verification/triangle_creator_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module triangle_creator_tb -f project.f -o sim_triangle_creator \
    && ./obj_dir/sim_triangle_creator +verilator+error+limit+100 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "TEST PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
